// File: sim.f
src/pu_spi_pkg.sv
src/spi_slave_driver.sv
src/spi_word_buffer.sv
src/spi_byte_packer.sv
src/spi_byte_unpacker.sv
src/pu_slave_spi.sv
tb/tb_pu_slave_spi.sv

// File: src/pu_slave_spi.sv
`timescale 1ns/1ps
`default_nettype none

module pu_slave_spi
	( input  logic               clk
	, input  logic               rst
	, input  logic               signal_cycle

	// Processor side
	, input  logic               signal_wr
	, input  pu_spi_pkg::word_t  data_in
	, input  logic               signal_oe
	, output pu_spi_pkg::word_t  data_out
	, output pu_spi_pkg::attr_t  attr_out

	, output logic               flag_start
	, output logic               flag_stop

	// SPI pins
	, input  logic               mosi
	, output logic               miso
	, input  logic               sclk
	, input  logic               cs
	);

logic buffer_clear;
logic copy_strobe;
pu_spi_pkg::word_t copy_word;

pu_spi_pkg::byte_t tx_byte;
pu_spi_pkg::byte_t rx_byte;
logic byte_done;
logic cs_fall;
logic cs_rise;

pu_spi_pkg::word_t packed_word;
logic word_valid;
logic word_take;

pu_spi_pkg::word_t transfer_head;
pu_spi_pkg::word_t receive_head;
pu_spi_pkg::word_t send_head;
logic transfer_empty;
logic receive_empty;
logic send_empty;
logic transfer_read;
logic receive_read;

spi_slave_driver spi_driver
	( .clk( clk ), .rst( rst )
	, .mosi( mosi ), .miso( miso ), .sclk( sclk ), .cs( cs )
	, .tx_byte( tx_byte ), .rx_byte( rx_byte ), .byte_done( byte_done )
	, .cs_fall( cs_fall ), .cs_rise( cs_rise )
	);

spi_byte_packer packer
	( .clk( clk ), .rst( rst ), .clear( buffer_clear )
	, .byte_done( byte_done ), .rx_byte( rx_byte )
	, .word( packed_word ), .word_valid( word_valid )
	);

spi_byte_unpacker unpacker
	( .clk( clk ), .rst( rst ), .clear( buffer_clear )
	, .byte_done( byte_done ), .cs_fall( cs_fall )
	, .head_word( send_head ), .head_empty( send_empty )
	, .tx_byte( tx_byte ), .word_take( word_take )
	);

// Processor writes, drained into the send store on signal_oe
spi_word_buffer transfer_buffer
	( .clk( clk ), .rst( rst ), .clear( buffer_clear )
	, .write( signal_wr ), .data_in( data_in )
	, .read( transfer_read ), .data_out( transfer_head )
	, .count( ), .empty( transfer_empty )
	);

// Words from the master
spi_word_buffer receive_buffer
	( .clk( clk ), .rst( rst ), .clear( buffer_clear )
	, .write( word_valid ), .data_in( packed_word )
	, .read( receive_read ), .data_out( receive_head )
	, .count( ), .empty( receive_empty )
	);

// Words for the master
spi_word_buffer send_buffer
	( .clk( clk ), .rst( rst ), .clear( buffer_clear )
	, .write( copy_strobe ), .data_in( copy_word )
	, .read( word_take ), .data_out( send_head )
	, .count( ), .empty( send_empty )
	);

assign transfer_read = signal_oe && !transfer_empty;
assign receive_read  = signal_oe && !receive_empty;

always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		buffer_clear <= 1'b0;
		copy_strobe  <= 1'b0;
		data_out     <= '0;
		attr_out     <= '0;
	end else begin
		buffer_clear <= signal_cycle;
		copy_strobe  <= transfer_read;
		if (signal_oe) begin
			data_out <= receive_empty ? '0 : receive_head;
			attr_out <= '0;
			attr_out[pu_spi_pkg::ATTR_INVALID_BIT] <= receive_empty;
		end
	end
end

// Head moves on the read, so hold the word for the copy
always_ff @(posedge clk) begin
	if (transfer_read) begin
		copy_word <= transfer_head;
	end
end

assign flag_start = cs_fall;
assign flag_stop  = cs_rise;

endmodule

`default_nettype wire

// File: src/pu_spi_pkg.sv
`default_nettype none

package pu_spi_pkg;

	// Processor side
	localparam int DATA_WIDTH = 32;
	localparam int ATTR_WIDTH = 4;

	// SPI side
	localparam int SPI_DATA_WIDTH = 8;
	localparam int BYTES_PER_WORD = DATA_WIDTH / SPI_DATA_WIDTH;
	localparam int BIT_CNT_WIDTH  = $clog2(SPI_DATA_WIDTH);
	localparam int BYTE_IDX_WIDTH = $clog2(BYTES_PER_WORD);

	// Buffer depth, count must reach BUF_SIZE itself
	localparam int BUF_SIZE  = 6;
	localparam int PTR_WIDTH = $clog2(BUF_SIZE + 1);

	// Attribute bit 0 marks a read past the received words
	localparam int ATTR_INVALID_BIT = 0;

	typedef logic [DATA_WIDTH-1:0]     word_t;
	typedef logic [ATTR_WIDTH-1:0]     attr_t;
	typedef logic [SPI_DATA_WIDTH-1:0] byte_t;
	typedef logic [PTR_WIDTH-1:0]      ptr_t;

endpackage

`default_nettype wire

// File: src/spi_byte_packer.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_packer
	( input  logic               clk
	, input  logic               rst
	, input  logic               clear

	, input  logic               byte_done
	, input  pu_spi_pkg::byte_t  rx_byte

	, output pu_spi_pkg::word_t  word
	, output logic               word_valid
	);

logic [pu_spi_pkg::BYTE_IDX_WIDTH-1:0] byte_cnt;
logic last_byte;

assign last_byte = (byte_cnt ==
	pu_spi_pkg::BYTE_IDX_WIDTH'(pu_spi_pkg::BYTES_PER_WORD - 1));

always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		byte_cnt   <= '0;
		word_valid <= 1'b0;
	end else if (clear) begin
		// Partial word is dropped
		byte_cnt   <= '0;
		word_valid <= 1'b0;
	end else begin
		word_valid <= byte_done && last_byte;
		if (byte_done) begin
			byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
		end
	end
end

// First byte ends up in the top byte of the word
always_ff @(posedge clk) begin
	if (byte_done) begin
		word <= {word[pu_spi_pkg::DATA_WIDTH-pu_spi_pkg::SPI_DATA_WIDTH-1:0], rx_byte};
	end
end

endmodule

`default_nettype wire

// File: src/spi_byte_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_unpacker
	( input  logic               clk
	, input  logic               rst
	, input  logic               clear

	, input  logic               byte_done
	, input  logic               cs_fall

	, input  pu_spi_pkg::word_t  head_word
	, input  logic               head_empty

	, output pu_spi_pkg::byte_t  tx_byte
	, output logic               word_take
	);

logic [pu_spi_pkg::BYTE_IDX_WIDTH-1:0] byte_idx;
logic last_byte;
logic from_store;
pu_spi_pkg::word_t word_reg;
pu_spi_pkg::byte_t head_byte;

// Zero goes out while the send store is empty
assign head_byte = head_empty ? '0 :
	head_word[pu_spi_pkg::DATA_WIDTH-1 -: pu_spi_pkg::SPI_DATA_WIDTH];

assign last_byte = (byte_idx ==
	pu_spi_pkg::BYTE_IDX_WIDTH'(pu_spi_pkg::BYTES_PER_WORD - 1));

// First byte of a word comes straight from the store head
assign tx_byte = (cs_fall || byte_idx == '0) ? head_byte :
	word_reg[pu_spi_pkg::DATA_WIDTH-1 -: pu_spi_pkg::SPI_DATA_WIDTH];

// Store pops on the last byte so the next head is ready for the reload
assign word_take = byte_done && last_byte && from_store;

always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		byte_idx   <= '0;
		from_store <= 1'b0;
	end else if (clear) begin
		byte_idx   <= '0;
		from_store <= 1'b0;
	end else if (cs_fall) begin
		// Unfinished word restarts from its first byte
		byte_idx <= '0;
	end else if (byte_done) begin
		if (byte_idx == '0) begin
			from_store <= !head_empty;
		end
		byte_idx <= last_byte ? '0 : byte_idx + 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (byte_done) begin
		if (byte_idx == '0) begin
			word_reg <= head_empty ? '0 : head_word << pu_spi_pkg::SPI_DATA_WIDTH;
		end else begin
			word_reg <= word_reg << pu_spi_pkg::SPI_DATA_WIDTH;
		end
	end
end

endmodule

`default_nettype wire

// File: src/spi_slave_driver.sv
`timescale 1ns/1ps
`default_nettype none

module spi_slave_driver
	( input  logic               clk
	, input  logic               rst

	, input  logic               mosi
	, output logic               miso
	, input  logic               sclk
	, input  logic               cs

	, input  pu_spi_pkg::byte_t  tx_byte
	, output pu_spi_pkg::byte_t  rx_byte
	, output logic               byte_done
	, output logic               cs_fall
	, output logic               cs_rise
	);

logic mosi_m, mosi_s;
logic sclk_m, sclk_s, sclk_d;
logic cs_m, cs_s, cs_d;
logic sclk_rise, sclk_fall;
logic tx_load;
logic [pu_spi_pkg::BIT_CNT_WIDTH-1:0] bit_cnt;
pu_spi_pkg::byte_t rx_shift;
pu_spi_pkg::byte_t tx_shift;

// Two-flop synchronizers plus one stage for edge detection
always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		mosi_m <= 1'b0;
		mosi_s <= 1'b0;
		sclk_m <= 1'b0;
		sclk_s <= 1'b0;
		sclk_d <= 1'b0;
		cs_m   <= 1'b1;
		cs_s   <= 1'b1;
		cs_d   <= 1'b1;
	end else begin
		mosi_m <= mosi;
		mosi_s <= mosi_m;
		sclk_m <= sclk;
		sclk_s <= sclk_m;
		sclk_d <= sclk_s;
		cs_m   <= cs;
		cs_s   <= cs_m;
		cs_d   <= cs_s;
	end
end

assign sclk_rise = sclk_s & ~sclk_d;
assign sclk_fall = ~sclk_s & sclk_d;

always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		bit_cnt   <= '0;
		byte_done <= 1'b0;
		cs_fall   <= 1'b0;
		cs_rise   <= 1'b0;
		tx_load   <= 1'b0;
		tx_shift  <= '0;
	end else begin
		cs_fall   <= cs_d & ~cs_s;
		cs_rise   <= ~cs_d & cs_s;
		byte_done <= 1'b0;
		tx_load   <= byte_done;
		if (cs_s) begin
			bit_cnt <= '0;
		end else if (sclk_rise) begin
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == '1) begin
				byte_done <= 1'b1;
			end
		end
		// The falling edge that closes a byte loads the next one instead of shifting
		if (cs_fall || tx_load) begin
			tx_shift <= tx_byte;
		end else if (!cs_s && sclk_fall && bit_cnt != '0) begin
			tx_shift <= {tx_shift[pu_spi_pkg::SPI_DATA_WIDTH-2:0], 1'b0};
		end
	end
end

always_ff @(posedge clk) begin
	if (!cs_s && sclk_rise) begin
		rx_shift <= {rx_shift[pu_spi_pkg::SPI_DATA_WIDTH-2:0], mosi_s};
		if (bit_cnt == '1) begin
			rx_byte <= {rx_shift[pu_spi_pkg::SPI_DATA_WIDTH-2:0], mosi_s};
		end
	end
end

assign miso = tx_shift[pu_spi_pkg::SPI_DATA_WIDTH-1];

a_byte_in_frame: assert property (@(posedge clk) disable iff (rst)
	byte_done |-> !cs_s)
	else $error("byte_done outside of a cs frame");

a_cs_edges_apart: assert property (@(posedge clk) disable iff (rst)
	(cs_fall || cs_rise) |=> !(cs_fall || cs_rise))
	else $error("cs_fall and cs_rise too close together");

endmodule

`default_nettype wire

// File: src/spi_word_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module spi_word_buffer
	( input  logic               clk
	, input  logic               rst
	, input  logic               clear

	, input  logic               write
	, input  pu_spi_pkg::word_t  data_in

	, input  logic               read
	, output pu_spi_pkg::word_t  data_out

	, output pu_spi_pkg::ptr_t   count
	, output logic               empty
	);

pu_spi_pkg::word_t mem [pu_spi_pkg::BUF_SIZE];
pu_spi_pkg::ptr_t  wr_ptr;
pu_spi_pkg::ptr_t  rd_ptr;
logic full;
logic do_write;
logic do_read;

function automatic pu_spi_pkg::ptr_t next_ptr(input pu_spi_pkg::ptr_t ptr);
	if (ptr == pu_spi_pkg::ptr_t'(pu_spi_pkg::BUF_SIZE - 1)) begin
		return '0;
	end
	return ptr + 1'b1;
endfunction

assign empty    = (count == '0);
assign full     = (count == pu_spi_pkg::ptr_t'(pu_spi_pkg::BUF_SIZE));
assign do_write = write && !full && !clear;
assign do_read  = read && !empty && !clear;

assign data_out = mem[rd_ptr];

always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count  <= '0;
	end else if (clear) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count  <= '0;
	end else begin
		if (do_write) begin
			wr_ptr <= next_ptr(wr_ptr);
		end
		if (do_read) begin
			rd_ptr <= next_ptr(rd_ptr);
		end
		case ({do_write, do_read})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (do_write) begin
		mem[wr_ptr] <= data_in;
	end
end

// Full writes are dropped, nothing upstream waits
a_no_write_full: assert property (@(posedge clk) disable iff (rst)
	(write && !clear) |-> !full)
	else $error("write to a full buffer dropped");

a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
	(read && !clear) |-> !empty)
	else $error("read from an empty buffer");

endmodule

`default_nettype wire

// File: tb/tb_pu_slave_spi.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pu_slave_spi;

localparam int SCLK_HALF  = 4;
localparam int WAIT_LIMIT = 400;

logic clk;
logic rst;
logic signal_cycle;
logic signal_wr;
logic signal_oe;
pu_spi_pkg::word_t data_in;
pu_spi_pkg::word_t data_out;
pu_spi_pkg::attr_t attr_out;
logic flag_start;
logic flag_stop;
logic mosi;
logic miso;
logic sclk;
logic cs;

integer seed;
int start_cnt;
int stop_cnt;
int frame_cnt;
logic oe_prev;
string test_name;

// Queue model of the three buffers
pu_spi_pkg::word_t transfer_q[$];
pu_spi_pkg::word_t receive_q[$];
pu_spi_pkg::word_t send_q[$];
pu_spi_pkg::word_t exp_data_q[$];
pu_spi_pkg::attr_t exp_attr_q[$];

pu_slave_spi dut0
	( .clk( clk ), .rst( rst ), .signal_cycle( signal_cycle )
	, .signal_wr( signal_wr ), .data_in( data_in ), .signal_oe( signal_oe )
	, .data_out( data_out ), .attr_out( attr_out )
	, .flag_start( flag_start ), .flag_stop( flag_stop )
	, .mosi( mosi ), .miso( miso ), .sclk( sclk ), .cs( cs )
	);

initial begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

task automatic fail_run(input string what);
	$display("%s", what);
	$display(">>> FAIL");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic check_word(input string name, input pu_spi_pkg::word_t exp,
	input pu_spi_pkg::word_t act);
	if (act !== exp) begin
		fail_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	end
endtask

task automatic check_attr(input string name, input pu_spi_pkg::attr_t exp,
	input pu_spi_pkg::attr_t act);
	if (act !== exp) begin
		fail_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	end
endtask

task automatic check_byte(input string name, input pu_spi_pkg::byte_t exp,
	input pu_spi_pkg::byte_t act);
	if (act !== exp) begin
		fail_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		fail_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
	end
endtask

task automatic check_count(input string name, input int exp, input int act);
	if (act != exp) begin
		fail_run($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
	end
endtask

// Expected result of one signal_oe
function automatic pu_spi_pkg::word_t expect_read(output pu_spi_pkg::attr_t attr);
	pu_spi_pkg::word_t w;
	attr = '0;
	w = '0;
	if (transfer_q.size() != 0 && send_q.size() < pu_spi_pkg::BUF_SIZE) begin
		send_q.push_back(transfer_q.pop_front());
	end
	if (receive_q.size() == 0) begin
		attr[0] = 1'b1;
	end else begin
		w = receive_q.pop_front();
	end
	return w;
endfunction

// Mosi word is stored and the send head goes out
function automatic pu_spi_pkg::word_t exchange_word(input pu_spi_pkg::word_t rx_word);
	pu_spi_pkg::word_t w;
	w = '0;
	if (receive_q.size() < pu_spi_pkg::BUF_SIZE) begin
		receive_q.push_back(rx_word);
	end
	if (send_q.size() != 0) begin
		w = send_q.pop_front();
	end
	return w;
endfunction

task automatic step_clocks(input int n);
	repeat (n) @(posedge clk);
	#1;
endtask

task automatic wait_count_above(input string what, input bit stop, input int level);
	int n;
	n = 0;
	while ((stop ? stop_cnt : start_cnt) <= level) begin
		@(posedge clk);
		n++;
		if (n > WAIT_LIMIT) begin
			fail_run($sformatf("Timeout while waiting for %s", what));
		end
	end
endtask

task automatic write_word(input pu_spi_pkg::word_t w);
	if (transfer_q.size() < pu_spi_pkg::BUF_SIZE) begin
		transfer_q.push_back(w);
	end
	signal_wr = 1'b1;
	data_in   = w;
	step_clocks(1);
	signal_wr = 1'b0;
	step_clocks(2);
endtask

task automatic read_word();
	pu_spi_pkg::word_t w;
	pu_spi_pkg::attr_t a;
	w = expect_read(a);
	exp_data_q.push_back(w);
	exp_attr_q.push_back(a);
	signal_oe = 1'b1;
	step_clocks(1);
	signal_oe = 1'b0;
	step_clocks(2);
endtask

task automatic new_cycle();
	transfer_q.delete();
	receive_q.delete();
	send_q.delete();
	signal_cycle = 1'b1;
	step_clocks(1);
	signal_cycle = 1'b0;
	step_clocks(3);
endtask

// Mode 0, MSB first, miso taken at the rising sclk
task automatic spi_byte(input pu_spi_pkg::byte_t tx, output pu_spi_pkg::byte_t rx);
	int i;
	for (i = pu_spi_pkg::SPI_DATA_WIDTH - 1; i >= 0; i--) begin
		mosi = tx[i];
		step_clocks(SCLK_HALF);
		sclk  = 1'b1;
		rx[i] = miso;
		step_clocks(SCLK_HALF);
		sclk = 1'b0;
	end
endtask

task automatic spi_frame(input string name, input int n_words);
	pu_spi_pkg::word_t tx_word;
	pu_spi_pkg::word_t exp_word;
	pu_spi_pkg::byte_t rx;
	int w;
	int b;
	cs = 1'b0;
	wait_count_above("flag_start", 1'b0, start_cnt);
	step_clocks(2);
	for (w = 0; w < n_words; w++) begin
		tx_word  = $random(seed);
		exp_word = exchange_word(tx_word);
		for (b = pu_spi_pkg::BYTES_PER_WORD - 1; b >= 0; b--) begin
			spi_byte(tx_word[b*pu_spi_pkg::SPI_DATA_WIDTH +: pu_spi_pkg::SPI_DATA_WIDTH], rx);
			check_byte($sformatf("%s miso word %0d byte %0d", name, w, b),
				exp_word[b*pu_spi_pkg::SPI_DATA_WIDTH +: pu_spi_pkg::SPI_DATA_WIDTH], rx);
		end
	end
	step_clocks(SCLK_HALF);
	cs = 1'b1;
	frame_cnt++;
	wait_count_above("flag_stop", 1'b1, stop_cnt);
	step_clocks(4);
	check_count({name, " flag_start pulses"}, frame_cnt, start_cnt);
	check_count({name, " flag_stop pulses"}, frame_cnt, stop_cnt);
endtask

// Outputs are compared at the falling edge
always @(negedge clk) begin
	if (flag_start) begin
		start_cnt++;
	end
	if (flag_stop) begin
		stop_cnt++;
	end
	if (oe_prev) begin
		if (exp_data_q.size() == 0) begin
			fail_run("A read result arrived with no read expected");
		end
		check_word({test_name, " data_out"}, exp_data_q.pop_front(), data_out);
		check_attr({test_name, " attr_out"}, exp_attr_q.pop_front(), attr_out);
	end
	oe_prev = signal_oe;
end

initial begin
	seed         = 73;
	start_cnt    = 0;
	stop_cnt     = 0;
	frame_cnt    = 0;
	oe_prev      = 1'b0;
	test_name    = "reset";
	rst          = 1'b1;
	signal_cycle = 1'b0;
	signal_wr    = 1'b0;
	signal_oe    = 1'b0;
	data_in      = '0;
	mosi         = 1'b0;
	sclk         = 1'b0;
	cs           = 1'b1;
	step_clocks(16);
	rst = 1'b0;
	step_clocks(2);
	@(negedge clk);
	check_word("reset data_out", '0, data_out);
	check_attr("reset attr_out", '0, attr_out);
	check_flag("reset flag_start", 1'b0, flag_start);
	check_flag("reset flag_stop", 1'b0, flag_stop);
	check_flag("reset miso", 1'b0, miso);
	step_clocks(1);

	test_name = "receive three words";
	spi_frame(test_name, 3);
	repeat (3) read_word();

	test_name = "read past received";
	read_word();

	// Two written words go out ahead of zero fill
	test_name = "send two words";
	write_word($random(seed));
	write_word($random(seed));
	read_word();
	read_word();
	spi_frame(test_name, 3);

	test_name = "cycle clears";
	write_word($random(seed));
	new_cycle();
	read_word();
	test_name = "after cycle";
	spi_frame(test_name, 1);
	read_word();
	read_word();

	step_clocks(3);
	check_count("pending read results", 0, exp_data_q.size());
	check_count("total flag_start pulses", frame_cnt, start_cnt);
	check_count("total flag_stop pulses", frame_cnt, stop_cnt);
	$display(">>> PASS");
	$finish;
end

endmodule

`default_nettype wire
